/* flist.f */
+incdir+source
source/imuldiv_pkg.sv
source/imuldiv_decode.sv
source/imuldiv_execute.sv
source/imuldiv_result.sv
source/imuldiv.sv
dv/imuldiv_tb.sv

/* Bender.yml */
package:
  name: imuldiv

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/imuldiv_pkg.sv
      - source/imuldiv_decode.sv
      - source/imuldiv_execute.sv
      - source/imuldiv_result.sv
      - source/imuldiv.sv
  - target: simulation
    files:
      - dv/imuldiv_tb.sv

/* dv/imuldiv_tb.sv */
/*
  testbench for the multiply/divide unit: clock, stimulus,
  reference model, scoreboard, checks and timeout
*/

module imuldiv_tb
  import imuldiv_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // 1 timing op, 10 directed mul, 12 directed div, two random passes of 300
  localparam int n_rand     = 300;
  localparam int total_ops  = 1 + 10 + 12 + 2 * n_rand;
  localparam int max_cycles = total_ops * 40 * 4 + 200;

  logic       clk;
  logic       reset;
  logic       req_val;
  logic       req_rdy;
  muldiv_op_e req_op;
  operand_t   req_a;
  operand_t   req_b;
  logic       resp_val;
  logic       resp_rdy;
  result_t    resp_result;

  // scoreboard, filled on request handshake
  result_t exp_q[$];
  string   name_q[$];
  string   cur_name;

  int   cycles;
  int   n_pass;
  int   n_fail;
  int   fail_mark;
  logic bp_mode;
  logic saw_stall;
  logic bp_bits [0:1023];

  // random stream, kept so the back-pressure pass replays it
  muldiv_op_e rnd_op [0:n_rand-1];
  operand_t   rnd_a  [0:n_rand-1];
  operand_t   rnd_b  [0:n_rand-1];

  imuldiv dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #50 clk = ~clk;

  // --------------------
  // reference model
  // --------------------

  // plain integer arithmetic plus the processor division rules
  function automatic result_t imuldiv_ref(input muldiv_op_e op, input operand_t a,
                                          input operand_t b);
    longint  sa;
    longint  sb;
    longint  q;
    longint  r;
    result_t res;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    case (op)
      op_mul:  res = result_t'(sa * sb);
      op_mulu: res = {32'h0, a} * {32'h0, b};
      op_div: begin
        if (b == '0) begin
          res = {a, 32'hffff_ffff};
        end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          res = {32'h0, 32'h8000_0000};
        end else begin
          // truncating divide, remainder takes the dividend's sign
          q   = sa / sb;
          r   = sa % sb;
          res = {r[31:0], q[31:0]};
        end
      end
      op_divu: begin
        if (b == '0) begin
          res = {a, 32'hffff_ffff};
        end else begin
          res = {a % b, a / b};
        end
      end
      default: res = '0;
    endcase
    return res;
  endfunction

  // --------------------
  // checks
  // --------------------

  task automatic check_result(input string name, input result_t exp, input result_t act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %b actual %b", name, exp, act);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  // --------------------
  // monitors
  // --------------------

  // handshake signals settle well before the falling edge
  always @(negedge clk) begin
    if (!reset && req_val && req_rdy) begin
      exp_q.push_back(imuldiv_ref(req_op, req_a, req_b));
      name_q.push_back(cur_name);
    end
    if (!reset && bp_mode && req_val && !req_rdy) begin
      saw_stall = 1'b1;
    end
  end

  always @(negedge clk) begin
    if (!reset && resp_val && resp_rdy) begin
      if (exp_q.size() == 0) begin
        $display("response %h arrived with no request outstanding", resp_result);
        n_fail++;
      end else begin
        check_result(name_q.pop_front(), exp_q.pop_front(), resp_result);
      end
    end
  end

  // cycle count and run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("run timed out after %0d cycles", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  // random back-pressure, one bit per cycle
  always @(posedge clk) begin
    #5;
    if (bp_mode) begin
      resp_rdy = bp_bits[cycles % 1024];
    end
  end

  // --------------------
  // stimulus helpers
  // --------------------

  // called 5 ns after a rising edge, returns 5 ns after the accept edge
  task automatic send(input muldiv_op_e op, input operand_t a, input operand_t b,
                      input string name);
    req_val  = 1'b1;
    req_op   = op;
    req_a    = a;
    req_b    = b;
    cur_name = name;
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    @(posedge clk);
    #5;
  endtask

  // wait until every expected response has been seen
  task automatic drain();
    req_val = 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    #5;
  endtask

  task automatic end_test(input string name);
    $display("test %-12s %s", name, (n_fail == fail_mark) ? "passed" : "had errors");
    fail_mark = n_fail;
  endtask

  // --------------------
  // test sequence
  // --------------------

  initial begin
    int lat;
    clk       = 1'b0;
    reset     = 1'b1;
    req_val   = 1'b0;
    req_op    = op_mul;
    req_a     = '0;
    req_b     = '0;
    resp_rdy  = 1'b1;
    cur_name  = "";
    cycles    = 0;
    n_pass    = 0;
    n_fail    = 0;
    fail_mark = 0;
    bp_mode   = 1'b0;
    saw_stall = 1'b0;
    void'($urandom(32'h3795b5b6));
    for (int i = 0; i < n_rand; i++) begin
      rnd_op[i] = muldiv_op_e'($urandom_range(0, 3));
      rnd_a[i]  = $urandom;
      // small divisors now and then, zero included
      rnd_b[i]  = ($urandom_range(0, 3) == 0) ? $urandom_range(0, 7) : $urandom;
    end
    for (int i = 0; i < 1024; i++) begin
      bp_bits[i] = $urandom_range(0, 1);
    end
    repeat (2) @(posedge clk);
    #5;
    reset = 1'b0;

    // idle state and single-op latency
    @(negedge clk);
    check_flag("reset_req_rdy", 1'b1, req_rdy);
    check_flag("reset_resp_val", 1'b0, resp_val);
    @(posedge clk);
    #5;
    send(op_mul, 32'd1234, 32'hffff_fff9, "latency_mul");
    req_val = 1'b0;
    lat = 0;
    forever begin
      @(negedge clk);
      if (resp_val) break;
      @(posedge clk);
      lat++;
    end
    check_count("latency", 34, lat);
    @(posedge clk);
    drain();
    end_test("latency");

    // directed multiplies
    send(op_mul,  32'h0,         32'h0001_2345, "mul_zero");
    send(op_mul,  32'h1,         32'hffff_fff9, "mul_one");
    send(op_mul,  32'hffff_ffff, 32'h7fff_ffff, "mul_m1");
    send(op_mul,  32'h8000_0000, 32'h8000_0000, "mul_min_sq");
    send(op_mul,  32'hffff_ffff, 32'hffff_ffff, "mul_ones");
    send(op_mulu, 32'h0,         32'hffff_ffff, "mulu_zero");
    send(op_mulu, 32'h1,         32'hffff_ffff, "mulu_one");
    send(op_mulu, 32'hffff_ffff, 32'h0000_0003, "mulu_m1");
    send(op_mulu, 32'h8000_0000, 32'h8000_0000, "mulu_min_sq");
    send(op_mulu, 32'hffff_ffff, 32'hffff_ffff, "mulu_ones");
    drain();
    end_test("directed_mul");

    // directed divides, corner rules and remainder signs
    send(op_div,  32'd100,       32'h0,         "div_zero_pos");
    send(op_div,  32'hffff_ff9c, 32'h0,         "div_zero_neg");
    send(op_div,  32'h8000_0000, 32'hffff_ffff, "div_ovf");
    send(op_div,  32'hffff_fff9, 32'd2,         "div_neg_pos");
    send(op_div,  32'd7,         32'hffff_fffe, "div_pos_neg");
    send(op_div,  32'hffff_fff9, 32'hffff_fffe, "div_neg_neg");
    send(op_div,  32'd3,         32'd10,        "div_small");
    send(op_divu, 32'd100,       32'h0,         "divu_zero");
    send(op_divu, 32'hffff_ffff, 32'h0,         "divu_zero_big");
    send(op_divu, 32'd3,         32'd10,        "divu_small");
    send(op_divu, 32'hffff_ffff, 32'd7,         "divu_big");
    send(op_divu, 32'd7,         32'd2,         "divu_basic");
    drain();
    end_test("directed_div");

    // random stream, response side always ready
    for (int i = 0; i < n_rand; i++) begin
      send(rnd_op[i], rnd_a[i], rnd_b[i], $sformatf("rand_%0d", i));
    end
    drain();
    end_test("random");

    // same stream under random back-pressure
    saw_stall = 1'b0;
    bp_mode   = 1'b1;
    for (int i = 0; i < n_rand; i++) begin
      send(rnd_op[i], rnd_a[i], rnd_b[i], $sformatf("bp_%0d", i));
    end
    drain();
    bp_mode  = 1'b0;
    resp_rdy = 1'b1;
    check_flag("bp_req_rdy_drop", 1'b1, saw_stall);
    end_test("backpressure");

    $display("checks passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* source/imuldiv.sv */
/*
  multiply/divide unit top, decode -> execute -> result
*/

module imuldiv
  import imuldiv_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       req_val,
  output logic       req_rdy,
  input  muldiv_op_e req_op,
  input  operand_t   req_a,
  input  operand_t   req_b,
  output logic       resp_val,
  input  logic       resp_rdy,
  output result_t    resp_result
);

  // decode to execute
  logic     dec_val;
  logic     dec_rdy;
  logic     dec_is_div;
  operand_t dec_a_mag;
  operand_t dec_b_mag;
  logic     dec_neg_lo;
  logic     dec_neg_hi;

  // execute to result
  logic     exe_val;
  logic     exe_rdy;
  logic     exe_is_div;
  result_t  exe_raw;
  logic     exe_neg_lo;
  logic     exe_neg_hi;

  // --------------------
  // stages
  // --------------------

  // holds one request, strips signs
  imuldiv_decode decode_i (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .req_op     (req_op),
    .req_a      (req_a),
    .req_b      (req_b),
    .dec_val    (dec_val),
    .dec_rdy    (dec_rdy),
    .dec_is_div (dec_is_div),
    .dec_a_mag  (dec_a_mag),
    .dec_b_mag  (dec_b_mag),
    .dec_neg_lo (dec_neg_lo),
    .dec_neg_hi (dec_neg_hi)
  );

  // 32 steps on unsigned magnitudes
  imuldiv_execute execute_i (
    .clk        (clk),
    .reset      (reset),
    .dec_val    (dec_val),
    .dec_rdy    (dec_rdy),
    .dec_is_div (dec_is_div),
    .dec_a_mag  (dec_a_mag),
    .dec_b_mag  (dec_b_mag),
    .dec_neg_lo (dec_neg_lo),
    .dec_neg_hi (dec_neg_hi),
    .exe_val    (exe_val),
    .exe_rdy    (exe_rdy),
    .exe_is_div (exe_is_div),
    .exe_raw    (exe_raw),
    .exe_neg_lo (exe_neg_lo),
    .exe_neg_hi (exe_neg_hi)
  );

  // puts signs back, holds the response
  imuldiv_result result_i (
    .clk         (clk),
    .reset       (reset),
    .exe_val     (exe_val),
    .exe_rdy     (exe_rdy),
    .exe_is_div  (exe_is_div),
    .exe_raw     (exe_raw),
    .exe_neg_lo  (exe_neg_lo),
    .exe_neg_hi  (exe_neg_hi),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

endmodule

/* source/imuldiv_result.sv */
/*
  sign restoration and response holding register
*/

`include "imuldiv_params.svh"

module imuldiv_result
  import imuldiv_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    exe_val,
  output logic    exe_rdy,
  input  logic    exe_is_div,
  input  result_t exe_raw,
  input  logic    exe_neg_lo,
  input  logic    exe_neg_hi,
  output logic    resp_val,
  input  logic    resp_rdy,
  output result_t resp_result
);

  localparam int XLEN = `IMULDIV_XLEN;
  localparam int RLEN = `IMULDIV_RLEN;

  logic     full_q;
  logic     load;
  result_t  resp_q;
  result_t  prod_signed;
  operand_t quo_signed;
  operand_t rem_signed;
  result_t  signed_word;

  // --------------------
  // handshake
  // --------------------

  // empty, or the held response leaves on this same edge
  assign exe_rdy = !full_q || resp_rdy;
  assign load    = exe_val && exe_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      full_q <= 1'b0;
    end
  end

  // --------------------
  // sign restoration
  // --------------------

  // multiply negates the whole product
  assign prod_signed = exe_neg_lo ? (~exe_raw + 1'b1) : exe_raw;

  // divide negates each half on its own flag
  assign quo_signed = exe_neg_lo ? (~exe_raw[XLEN-1:0] + 1'b1) : exe_raw[XLEN-1:0];
  assign rem_signed = exe_neg_hi ? (~exe_raw[RLEN-1:XLEN] + 1'b1) : exe_raw[RLEN-1:XLEN];

  assign signed_word = exe_is_div ? {rem_signed, quo_signed} : prod_signed;

  always_ff @(posedge clk) begin
    if (load) begin
      resp_q <= signed_word;
    end
  end

  assign resp_val    = full_q;
  assign resp_result = resp_q;

endmodule

/* source/imuldiv_execute.sv */
/*
  iterative shift-add multiply and restoring divide
  sharing one accumulator, one shifter and one adder
*/

`include "imuldiv_params.svh"

module imuldiv_execute
  import imuldiv_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     dec_val,
  output logic     dec_rdy,
  input  logic     dec_is_div,
  input  operand_t dec_a_mag,
  input  operand_t dec_b_mag,
  input  logic     dec_neg_lo,
  input  logic     dec_neg_hi,
  output logic     exe_val,
  input  logic     exe_rdy,
  output logic     exe_is_div,
  output result_t  exe_raw,
  output logic     exe_neg_lo,
  output logic     exe_neg_hi
);

  localparam int XLEN  = `IMULDIV_XLEN;
  localparam int RLEN  = `IMULDIV_RLEN;
  localparam int CNT_W = $clog2(`IMULDIV_STEPS);
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`IMULDIV_STEPS - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_step,
    st_done
  } state_e;

  state_e           state_q;
  logic [CNT_W-1:0] cnt_q;
  logic             load;
  logic             step;
  logic             unload;

  // sign flags ride along untouched
  logic     is_div_q;
  logic     neg_lo_q;
  logic     neg_hi_q;
  // product, or remainder:quotient pair
  result_t  acc_q;
  // multiplicand, moves left one place per step
  result_t  mcand_q;
  // multiplier shifting right, or the fixed divisor
  operand_t b_q;

  logic [XLEN:0] rem_sh;
  result_t       add_x;
  result_t       add_y;
  logic          add_cin;
  logic [RLEN:0] add_sum;
  logic          fits;
  result_t       acc_step;

  assign load    = dec_val && dec_rdy;
  assign unload  = exe_val && exe_rdy;
  assign step    = (state_q == st_step);
  assign dec_rdy = (state_q == st_idle);
  assign exe_val = (state_q == st_done);

  // --------------------
  // control FSM
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (load) begin
            state_q <= st_step;
            cnt_q   <= '0;
          end
        end
        st_step: begin
          cnt_q <= cnt_q + 1'b1;
          // last step lands on the edge that raises exe_val
          if (cnt_q == LAST_STEP) begin
            state_q <= st_done;
          end
        end
        st_done: begin
          if (unload) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // --------------------
  // shared adder
  // --------------------

  // remainder after the pair moves left, keeps the bit shifted out on top
  assign rem_sh = acc_q[RLEN-1:XLEN-1];

  always_comb begin
    if (is_div_q) begin
      // trial subtract as add of the inverted divisor plus one
      add_x   = {{(RLEN-XLEN-1){1'b0}}, rem_sh};
      add_y   = ~{{XLEN{1'b0}}, b_q};
      add_cin = 1'b1;
    end else begin
      add_x   = acc_q;
      add_y   = mcand_q;
      add_cin = 1'b0;
    end
  end

  assign add_sum = {1'b0, add_x} + {1'b0, add_y} + {{RLEN{1'b0}}, add_cin};

  // carry out means no borrow, the divisor fits
  assign fits = add_sum[RLEN];

  always_comb begin
    if (is_div_q) begin
      if (fits) begin
        acc_step = {add_sum[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
      end else begin
        acc_step = {rem_sh[XLEN-1:0], acc_q[XLEN-2:0], 1'b0};
      end
    end else if (b_q[0]) begin
      acc_step = add_sum[RLEN-1:0];
    end else begin
      acc_step = acc_q;
    end
  end

  // --------------------
  // datapath registers
  // --------------------

  always_ff @(posedge clk) begin
    if (load) begin
      // divide starts with the dividend in the quotient half
      acc_q    <= dec_is_div ? {{XLEN{1'b0}}, dec_a_mag} : '0;
      mcand_q  <= {{XLEN{1'b0}}, dec_a_mag};
      b_q      <= dec_b_mag;
      is_div_q <= dec_is_div;
      neg_lo_q <= dec_neg_lo;
      neg_hi_q <= dec_neg_hi;
    end else if (step) begin
      acc_q <= acc_step;
      // divisor stays put for a divide
      if (!is_div_q) begin
        mcand_q <= mcand_q << 1;
        b_q     <= b_q >> 1;
      end
    end
  end

  assign exe_is_div = is_div_q;
  assign exe_raw    = acc_q;
  assign exe_neg_lo = neg_lo_q;
  assign exe_neg_hi = neg_hi_q;

endmodule

/* source/imuldiv_decode.sv */
/*
  request holding register with operand sign removal
  and sign bookkeeping for the result stage
*/

`include "imuldiv_params.svh"

module imuldiv_decode
  import imuldiv_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       req_val,
  output logic       req_rdy,
  input  muldiv_op_e req_op,
  input  operand_t   req_a,
  input  operand_t   req_b,
  output logic       dec_val,
  input  logic       dec_rdy,
  output logic       dec_is_div,
  output operand_t   dec_a_mag,
  output operand_t   dec_b_mag,
  output logic       dec_neg_lo,
  output logic       dec_neg_hi
);

  localparam int XLEN = `IMULDIV_XLEN;

  logic     full_q;
  logic     load;
  logic     is_signed;
  logic     is_div;
  logic     a_neg;
  logic     b_neg;
  logic     b_zero;
  operand_t a_mag;
  operand_t b_mag;

  // --------------------
  // handshake
  // --------------------

  // free slot, or the held request leaves on this same edge
  assign req_rdy = !full_q || dec_rdy;
  assign load    = req_val && req_rdy;
  assign dec_val = full_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (dec_val && dec_rdy) begin
      full_q <= 1'b0;
    end
  end

  // --------------------
  // sign removal
  // --------------------

  assign is_signed = (req_op == op_mul) || (req_op == op_div);
  assign is_div    = (req_op == op_div) || (req_op == op_divu);

  // only signed ops look at the top bit
  assign a_neg  = is_signed && req_a[XLEN-1];
  assign b_neg  = is_signed && req_b[XLEN-1];
  assign b_zero = (req_b == '0);

  // two's complement, most negative value maps onto its own magnitude
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  // payload only changes on accept
  always_ff @(posedge clk) begin
    if (load) begin
      dec_is_div <= is_div;
      dec_a_mag  <= a_mag;
      dec_b_mag  <= b_mag;
      // product or quotient sign, a zero divisor keeps the all-ones quotient
      dec_neg_lo <= (a_neg ^ b_neg) && !(is_div && b_zero);
      // remainder follows the dividend
      dec_neg_hi <= is_div && a_neg;
    end
  end

endmodule

/* source/imuldiv_pkg.sv */
/*
  operation codes and operand/result types of the multiply/divide unit
*/

`include "imuldiv_params.svh"

package imuldiv_pkg;

  // --------------------
  // operation codes
  // --------------------

  // signed ops strip signs in decode, unsigned ops pass through
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_mulu = 2'd1,
    op_div  = 2'd2,
    op_divu = 2'd3
  } muldiv_op_e;

  // --------------------
  // data words
  // --------------------

  // one operand, or its magnitude after sign removal
  typedef logic [`IMULDIV_XLEN-1:0] operand_t;

  // full product, or remainder in the upper half and quotient in the lower
  typedef logic [`IMULDIV_RLEN-1:0] result_t;

endpackage

/* source/imuldiv_params.svh */
/*
  width and iteration count macros for the multiply/divide unit
*/

`ifndef IMULDIV_PARAMS_SVH
`define IMULDIV_PARAMS_SVH

// operand width in bits
`define IMULDIV_XLEN 32

// response width, product or remainder:quotient pair
`define IMULDIV_RLEN (2 * `IMULDIV_XLEN)

// one shift-add or restoring step per operand bit
`define IMULDIV_STEPS `IMULDIV_XLEN

`endif
